// ==== design/rv_core_params.svh ====
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

`default_nettype none

`define RV_XLEN        32 // data word width
`define RV_REG_ADDR_W  5  // register index width
`define RV_REG_COUNT   32 // architectural registers, x0 included

`define RV_WORD_ZERO   {`RV_XLEN{1'b0}} // register reset value

`default_nettype wire

`endif

// ==== design/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    // major opcodes kept from RV32I
    typedef enum logic [6:0] {
        op_reg = 7'b0110011, // OP
        op_imm = 7'b0010011, // OP-IMM
        op_lui = 7'b0110111  // LUI
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_pass_b // lui
    } alu_op_t;

endpackage : rv_core_pkg

`default_nettype wire

// ==== design/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_core_params.svh"
`default_nettype none

module rv_decode (
    input  logic                      instr_mem_resp,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  logic [`RV_XLEN-1:0]       instr,
    output logic                      dec_valid,
    output rv_core_pkg::alu_op_t      dec_op,
    output logic                      dec_wr,
    output logic [`RV_REG_ADDR_W-1:0] dec_rd,
    output logic [`RV_REG_ADDR_W-1:0] dec_rs1,
    output logic [`RV_REG_ADDR_W-1:0] dec_rs2,
    output logic [`RV_XLEN-1:0]       dec_imm,
    output logic                      dec_use_imm
);
    import rv_core_pkg::*;

    opcode_t                   opcode;
    logic [2:0]                funct3;
    logic                      alt;      // sub / sra select
    logic                      is_shift;
    logic                      legal;
    alu_op_t                   alu_op;
    logic                      use_imm;
    logic [`RV_XLEN-1:0]       imm;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_REG_ADDR_W-1:0] rs1;

    assign opcode   = opcode_t'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rd       = instr[11:7];
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    // for OP-IMM, funct7 only matters to split srai from srli
    assign alt = instr[30] && ((opcode == op_reg) || (funct3 == 3'b101));

    always_comb begin
        case (funct3)
            3'b000:  alu_op = alt ? alu_sub : alu_add;
            3'b001:  alu_op = alu_sll;
            3'b010:  alu_op = alu_slt;
            3'b011:  alu_op = alu_sltu;
            3'b100:  alu_op = alu_xor;
            3'b101:  alu_op = alt ? alu_sra : alu_srl;
            3'b110:  alu_op = alu_or;
            default: alu_op = alu_and;
        endcase

        legal   = 1'b1;
        use_imm = 1'b1;
        rs1     = instr[19:15];
        imm     = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]}; // I-type

        case (opcode)
            op_reg: use_imm = 1'b0;
            op_imm: begin
                if (is_shift) begin
                    imm = {{(`RV_XLEN-5){1'b0}}, instr[24:20]}; // shamt
                end
            end
            op_lui: begin
                alu_op = alu_pass_b;
                imm    = {instr[31:12], 12'b0}; // U-type
                rs1    = '0;
            end
            default: legal = 1'b0; // retires nothing
        endcase
    end

    always_ff @(posedge instr_mem_resp or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
            dec_wr    <= 1'b0;
        end else begin
            dec_valid <= instr_valid && legal;
            dec_wr    <= instr_valid && legal && (rd != '0); // x0 never written
        end
    end

    always_ff @(posedge instr_mem_resp) begin
        if (instr_valid) begin
            dec_op      <= alu_op;
            dec_rd      <= rd;
            dec_rs1     <= rs1;
            dec_rs2     <= instr[24:20];
            dec_imm     <= imm;
            dec_use_imm <= use_imm;
        end
    end

endmodule : rv_decode

`default_nettype wire

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_core_params.svh"
`default_nettype none

module rv_execute (
    input  logic                      instr_mem_resp,
    input  logic                      rst,
    input  logic                      dec_valid,
    input  rv_core_pkg::alu_op_t      dec_op,
    input  logic                      dec_wr,
    input  logic [`RV_REG_ADDR_W-1:0] dec_rd,
    input  logic [`RV_REG_ADDR_W-1:0] dec_rs1,
    input  logic [`RV_REG_ADDR_W-1:0] dec_rs2,
    input  logic [`RV_XLEN-1:0]       dec_imm,
    input  logic                      dec_use_imm,
    output logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    output logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    input  logic [`RV_XLEN-1:0]       rs1_data,
    input  logic [`RV_XLEN-1:0]       rs2_data,
    output logic                      ex_valid,
    output logic                      ex_wr,
    output logic [`RV_REG_ADDR_W-1:0] ex_rd,
    output logic [`RV_XLEN-1:0]       ex_value
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] fwd_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_res;

    // the previous instruction is still in the ex register, take it from there
    function automatic logic [`RV_XLEN-1:0] fwd(input logic [`RV_REG_ADDR_W-1:0] src,
                                                 input logic [`RV_XLEN-1:0] rf_data);
        if (ex_valid && ex_wr && (ex_rd == src)) begin
            return ex_value;
        end
        return rf_data;
    endfunction

    assign rs1_addr = dec_rs1;
    assign rs2_addr = dec_rs2;

    assign op_a  = fwd(dec_rs1, rs1_data);
    assign fwd_b = fwd(dec_rs2, rs2_data);
    assign op_b  = dec_use_imm ? dec_imm : fwd_b;
    assign shamt = op_b[4:0];

    always_comb begin
        alu_res = '0;
        unique case (dec_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_sll:    alu_res = op_a << shamt;
            alu_srl:    alu_res = op_a >> shamt;
            alu_sra:    alu_res = $signed(op_a) >>> shamt;
            alu_slt:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            alu_xor:    alu_res = op_a ^ op_b;
            alu_or:     alu_res = op_a | op_b;
            alu_and:    alu_res = op_a & op_b;
            alu_pass_b: alu_res = op_b; // lui
            default:    ;
        endcase
    end

    always_ff @(posedge instr_mem_resp or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_wr    <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
            ex_wr    <= dec_valid && dec_wr;
        end
    end

    always_ff @(posedge instr_mem_resp) begin
        if (dec_valid) begin
            ex_rd    <= dec_rd;
            ex_value <= alu_res;
        end
    end

endmodule : rv_execute

`default_nettype wire

// ==== design/rv_result.sv ====
`timescale 1ns/1ps
`include "rv_core_params.svh"
`default_nettype none

module rv_result (
    input  logic                      instr_mem_resp,
    input  logic                      rst,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]       rs1_data,
    output logic [`RV_XLEN-1:0]       rs2_data,
    input  logic                      ex_valid,
    input  logic                      ex_wr,
    input  logic [`RV_REG_ADDR_W-1:0] ex_rd,
    input  logic [`RV_XLEN-1:0]       ex_value,
    output logic                      retire_valid,
    output logic [`RV_REG_ADDR_W-1:0] retire_rd,
    output logic [`RV_XLEN-1:0]       retire_value
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT-1:1]; // x0 has no storage

    function automatic logic [`RV_XLEN-1:0] rf_read(input logic [`RV_REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return `RV_WORD_ZERO;
        end
        return regs[addr];
    endfunction

    assign rs1_data = rf_read(rs1_addr);
    assign rs2_data = rf_read(rs2_addr);

    always_ff @(posedge instr_mem_resp or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= `RV_WORD_ZERO;
            end
            retire_valid <= 1'b0;
        end else begin
            if (ex_wr) begin
                regs[ex_rd] <= ex_value; // ex_rd never zero here
            end
            retire_valid <= ex_valid;
        end
    end

    // rd zero still retires with its value
    always_ff @(posedge instr_mem_resp) begin
        if (ex_valid) begin
            retire_rd    <= ex_rd;
            retire_value <= ex_value;
        end
    end

endmodule : rv_result

`default_nettype wire

// ==== design/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_core_params.svh"
`default_nettype none

module rv_core (
    input  logic                      instr_mem_resp,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  logic [`RV_XLEN-1:0]       instr,
    output logic                      retire_valid,
    output logic [`RV_REG_ADDR_W-1:0] retire_rd,
    output logic [`RV_XLEN-1:0]       retire_value
);

    logic                      dec_valid;
    rv_core_pkg::alu_op_t      dec_op;
    logic                      dec_wr;
    logic [`RV_REG_ADDR_W-1:0] dec_rd;
    logic [`RV_REG_ADDR_W-1:0] dec_rs1;
    logic [`RV_REG_ADDR_W-1:0] dec_rs2;
    logic [`RV_XLEN-1:0]       dec_imm;
    logic                      dec_use_imm;

    logic [`RV_REG_ADDR_W-1:0] rs1_addr;
    logic [`RV_REG_ADDR_W-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;

    logic                      ex_valid;
    logic                      ex_wr;
    logic [`RV_REG_ADDR_W-1:0] ex_rd;
    logic [`RV_XLEN-1:0]       ex_value;

    rv_decode u_decode (
        .instr_mem_resp (instr_mem_resp),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .dec_valid      (dec_valid),
        .dec_op         (dec_op),
        .dec_wr         (dec_wr),
        .dec_rd         (dec_rd),
        .dec_rs1        (dec_rs1),
        .dec_rs2        (dec_rs2),
        .dec_imm        (dec_imm),
        .dec_use_imm    (dec_use_imm)
    );

    rv_execute u_execute (
        .instr_mem_resp (instr_mem_resp),
        .rst            (rst),
        .dec_valid      (dec_valid),
        .dec_op         (dec_op),
        .dec_wr         (dec_wr),
        .dec_rd         (dec_rd),
        .dec_rs1        (dec_rs1),
        .dec_rs2        (dec_rs2),
        .dec_imm        (dec_imm),
        .dec_use_imm    (dec_use_imm),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_data       (rs1_data), // combinational from regfile
        .rs2_data       (rs2_data),
        .ex_valid       (ex_valid),
        .ex_wr          (ex_wr),
        .ex_rd          (ex_rd),
        .ex_value       (ex_value)
    );

    rv_result u_result (
        .instr_mem_resp (instr_mem_resp),
        .rst            (rst),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .ex_valid       (ex_valid),
        .ex_wr          (ex_wr),
        .ex_rd          (ex_rd),
        .ex_value       (ex_value),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_value   (retire_value)
    );

endmodule : rv_core

`default_nettype wire

// ==== testbench/rv_core_chk.sv ====
`timescale 1ns/1ps
`include "rv_core_params.svh"
`default_nettype none

module rv_core_chk (
    input logic                instr_mem_resp,
    input logic                rst,
    input logic                instr_valid,
    input logic                retire_valid,
    input logic [`RV_XLEN-1:0] retire_value
);
    int fail_count = 0;

    reset_quiet: assert property (@(posedge instr_mem_resp)
        (rst || $past(rst)) |-> !retire_valid)
        else begin
            $error("retire_valid high during or right after reset");
            fail_count++;
        end

    // instruction sampled at edge k shows up at edge k+3
    retire_has_source: assert property (@(posedge instr_mem_resp) disable iff (rst)
        retire_valid |-> $past(instr_valid, 3))
        else begin
            $error("retire_valid without an instruction strobe three cycles before");
            fail_count++;
        end

    retire_value_known: assert property (@(posedge instr_mem_resp)
        retire_valid |-> !$isunknown(retire_value))
        else begin
            $error("retire_value unknown while retire_valid is high");
            fail_count++;
        end

endmodule : rv_core_chk

bind rv_core rv_core_chk u_chk (
    .instr_mem_resp (instr_mem_resp),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .retire_valid   (retire_valid),
    .retire_value   (retire_value)
);

`default_nettype wire

// ==== testbench/rv_core_monitor.sv ====
`timescale 1ns/1ps
`include "rv_core_params.svh"
`default_nettype none

module rv_core_monitor #(
    parameter int PASSES = 1 // times the file is replayed
) (
    input  logic                      instr_mem_resp,
    input  logic                      rst,
    input  logic                      retire_valid,
    input  logic [`RV_REG_ADDR_W-1:0] retire_rd,
    input  logic [`RV_XLEN-1:0]       retire_value,
    output logic                      all_retired,
    output int                        mismatch_count,
    output int                        unexpected_count,
    output int                        missing_count
);
    localparam int MAX_TESTS = 64;

    logic [31:0] tests [0:4*MAX_TESTS-1];
    int          pending [$]; // line numbers still to retire, in order
    int          n;

    initial begin
        mismatch_count   = 0;
        unexpected_count = 0;
        for (int i = 0; i < 4 * MAX_TESTS; i++) begin
            tests[i] = 32'hdead_0000 | i;
        end
        $readmemh("testbench/rv_core_tests.txt", tests);
        for (int p = 0; p < PASSES; p++) begin
            for (int t = 0; t < MAX_TESTS && tests[4*t+1] <= 1; t++) begin
                if (tests[4*t+1] == 1) begin
                    pending.push_back(t); // flag 0 lines never retire
                end
            end
        end
        missing_count = pending.size();
        all_retired   = (pending.size() == 0);

        forever begin
            @(negedge instr_mem_resp); // retire ports settled
            if (!rst && retire_valid) begin
                if (pending.size() == 0) begin
                    $display("retire of x%0d at %0t with no expected instruction left",
                             retire_rd, $time);
                    unexpected_count++;
                end else begin
                    n = pending.pop_front();
                    if (retire_rd !== tests[4*n+2][`RV_REG_ADDR_W-1:0] ||
                        retire_value !== tests[4*n+3]) begin
                        $display("FAILED %0t: test %0d retired x%0d = %h, expected x%0d = %h",
                                 $time, n, retire_rd, retire_value,
                                 tests[4*n+2][`RV_REG_ADDR_W-1:0], tests[4*n+3]);
                        mismatch_count++;
                    end
                end
            end
            missing_count = pending.size();
            all_retired   = (pending.size() == 0);
        end
    end

    final begin
        if (missing_count != 0) begin
            $display("%0d expected retires never arrived", missing_count);
        end
    end

endmodule : rv_core_monitor

`default_nettype wire

// ==== testbench/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_core_params.svh"
`default_nettype none

module rv_core_tb;
    localparam int MAX_TESTS = 64;
    localparam int PASSES    = 2; // first pass back to back, then with random gaps

    logic                      instr_mem_resp = 1'b0;
    logic                      rst;
    logic                      instr_valid;
    logic [`RV_XLEN-1:0]       instr;
    logic                      retire_valid;
    logic [`RV_REG_ADDR_W-1:0] retire_rd;
    logic [`RV_XLEN-1:0]       retire_value;
    logic                      all_retired;
    int                        mismatch_count;
    int                        unexpected_count;
    int                        missing_count;

    logic [31:0] tests [0:4*MAX_TESTS-1]; // 4 words per test line
    int          num_tests;
    int          cycle_limit = 0;
    int          cycles = 0;
    int          seed;
    int          idle;

    rv_core DUT (
        .instr_mem_resp (instr_mem_resp),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_value   (retire_value)
    );

    rv_core_monitor #(
        .PASSES (PASSES)
    ) u_monitor (
        .instr_mem_resp   (instr_mem_resp),
        .rst              (rst),
        .retire_valid     (retire_valid),
        .retire_rd        (retire_rd),
        .retire_value     (retire_value),
        .all_retired      (all_retired),
        .mismatch_count   (mismatch_count),
        .unexpected_count (unexpected_count),
        .missing_count    (missing_count)
    );

    task automatic print_error_counts();
        $display("errors: %0d wrong retires, %0d unexpected retires, %0d missing retires, %0d %s",
                 mismatch_count, unexpected_count, missing_count, DUT.u_chk.fail_count,
                 "assertion failures");
    endtask

    always #5 instr_mem_resp = ~instr_mem_resp;

    always @(posedge instr_mem_resp) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the DUT did not retire all tests within %0d cycles", cycle_limit);
            print_error_counts();
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        seed        = 32'hd321_6b6a;
        for (int i = 0; i < 4 * MAX_TESTS; i++) begin
            tests[i] = 32'hdead_0000 | i; // flag slot above 1 marks the end
        end
        $readmemh("testbench/rv_core_tests.txt", tests);
        num_tests = 0;
        while (num_tests < MAX_TESTS && tests[4*num_tests+1] <= 1) begin
            num_tests++;
        end
        cycle_limit = num_tests * PASSES * 3 + 20;

        repeat (2) @(posedge instr_mem_resp);
        #1;
        rst = 1'b0;
        for (int p = 0; p < PASSES; p++) begin
            for (int n = 0; n < num_tests; n++) begin
                instr_valid = 1'b1;
                instr       = tests[4*n];
                @(posedge instr_mem_resp);
                #1;
                instr_valid = 1'b0;
                idle        = 0; // first pass keeps dependent pairs back to back
                if (p > 0) begin
                    idle = $unsigned($random(seed)) % 3; // 0 gives back to back
                end
                repeat (idle) begin
                    @(posedge instr_mem_resp);
                    #1;
                end
            end
        end

        wait (all_retired);
        repeat (3) @(posedge instr_mem_resp); // catch a stray retire
        #1;
        print_error_counts();
        if (mismatch_count + unexpected_count + missing_count + DUT.u_chk.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : rv_core_tb

`default_nettype wire

// ==== testbench/rv_core_tests.txt ====
// columns: instruction word, retire flag, rd, expected retire value
ffb00093 1 01 fffffffb // addi x1, x0, -5
12345137 1 02 12345000 // lui x2, 0x12345
ffc0a193 1 03 00000001 // slti x3, x1, -4
0050b213 1 04 00000000 // sltiu x4, x1, 5
f0014293 1 05 edcbaf00 // xori x5, x2, -256
0f02e313 1 06 edcbaff0 // ori x6, x5, 0x0f0
7ff37393 1 07 000007f0 // andi x7, x6, 0x7ff
00409413 1 08 ffffffb0 // slli x8, x1, 4
00845493 1 09 00ffffff // srli x9, x8, 8
40845513 1 0a ffffffff // srai x10, x8, 8
00000063 0 00 00000000 // beq, no retire
001105b3 1 0b 12344ffb // add x11, x2, x1
40258633 1 0c fffffffb // sub x12, x11, x2
00002683 0 00 00000000 // lw, no retire
003626b3 1 0d 00000001 // slt x13, x12, x3
00c1b733 1 0e 00000001 // sltu x14, x3, x12
00d117b3 1 0f 2468a000 // sll x15, x2, x13
0070d833 1 10 0000ffff // srl x16, x1, x7 (shift 16)
4070d8b3 1 11 ffffffff // sra x17, x1, x7
00234933 1 12 fffffff0 // xor x18, x6, x2
009979b3 1 13 00fffff0 // and x19, x18, x9
00198013 1 00 00fffff1 // addi x0, x19, 1
0009ea33 1 14 00fffff0 // or x20, x19, x0

// ==== build.f ====
+incdir+design
design/rv_core_pkg.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_core.sv
testbench/rv_core_chk.sv
testbench/rv_core_monitor.sv
testbench/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --Mdir "$BUILD_DIR" \
    --top-module rv_core_tb -f build.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
"$BUILD_DIR/rv_core_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "test run failed, see $LOG"
    exit 1
fi
exit 0
